/* verilog.f */
+incdir+common
common/cpu_io_pkg.sv
common/cpu_io_if.sv
uart/uart_phy.sv
uart/uart_lite.sv
verilog/io_issue.sv
verilog/io_sequencer.sv
verilog/io_cpu.sv
verif/io_cpu_assertions.sv
verif/io_cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module io_cpu_tb -f verilog.f -o io_cpu_sim \
    && ./obj_dir/io_cpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && exit 0 || exit 1

/* verif/io_cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_io_cfg.svh"

module io_cpu_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_OPS   = 200;
    // directed ops first, then the random run
    localparam int NUM_OPS      = 18 + RANDOM_OPS;
    localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
    localparam int OP_CYCLES    = 12 * FRAME_CYCLES + 50;

    logic                clk;
    logic                rstn;
    logic                op_valid;
    cpu_io_pkg::io_op_t  op_code;
    cpu_io_pkg::byte_t   op_data;
    logic                op_ready;
    cpu_io_pkg::word_t   in_word;
    cpu_io_pkg::byte_t   led;
    logic                rx;
    logic                tx;

    // model of the sent bytes and of register 0
    cpu_io_pkg::byte_t   sent_q[$];
    cpu_io_pkg::word_t   model_word;
    cpu_io_pkg::byte_t   burst[4];
    int                  errors;
    int                  ops_done;

    // serial loopback
    assign rx = tx;

    io_cpu uut (
        .clk      (clk),
        .rstn     (rstn),
        .op_valid (op_valid),
        .op_code  (op_code),
        .op_data  (op_data),
        .op_ready (op_ready),
        .in_word  (in_word),
        .led      (led),
        .rx       (rx),
        .tx       (tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic cpu_io_pkg::io_op_t in_op_for_lane(input int lane);
        case (lane)
            1:       return cpu_io_pkg::OP_IN_LH;
            2:       return cpu_io_pkg::OP_IN_UL;
            3:       return cpu_io_pkg::OP_IN_UH;
            default: return cpu_io_pkg::OP_IN_LL;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors = errors + 1;
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    endtask

    //==================================================
    // one op through the interlock
    //==================================================
    task automatic issue_and_wait(input cpu_io_pkg::io_op_t op, input cpu_io_pkg::byte_t data);
        @(posedge clk);
        op_valid <= 1'b1;
        op_code  <= op;
        op_data  <= data;
        @(posedge clk);
        op_valid <= 1'b0;
        // stall must start right after acceptance
        @(negedge clk);
        check_value("op_ready", 32'd0, 32'(op_ready));
        while (!op_ready) @(negedge clk);
        ops_done = ops_done + 1;
    endtask

    task automatic check_outputs();
        check_value("in_word", model_word, in_word);
        check_value("led", 32'(model_word[7:0]), 32'(led));
    endtask

    task automatic run_out(input cpu_io_pkg::byte_t data);
        issue_and_wait(cpu_io_pkg::OP_OUT, data);
        sent_q.push_back(data);
        check_outputs();
    endtask

    task automatic run_in(input int lane);
        issue_and_wait(in_op_for_lane(lane), 8'h00);
        if (sent_q.size() == 0) begin
            errors = errors + 1;
            $display("in op issued with no byte outstanding at %0t", $time);
        end else begin
            model_word[lane*8 +: 8] = sent_q.pop_front();
        end
        check_outputs();
    endtask

    // outstanding bytes stay within the rx fifo depth
    task automatic run_random(input int count);
        int pick;
        for (int i = 0; i < count; i++) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            if (sent_q.size() == 0) pick = 0;
            else if (sent_q.size() >= `RX_FIFO_DEPTH) pick = 1;
            else pick = $urandom_range(1, 0);
            if (pick == 0) run_out(8'($urandom));
            else run_in($urandom_range(3, 0));
        end
    endtask

    initial begin
        #(CLK_PERIOD * OP_CYCLES * (NUM_OPS + 1));
        $display("timeout, op_ready never returned after %0d ops", ops_done);
        $display("Errors found");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        op_valid   = 1'b0;
        op_code    = cpu_io_pkg::OP_OUT;
        op_data    = '0;
        model_word = '0;
        errors     = 0;
        ops_done   = 0;
        void'($urandom(9239));

        apply_reset();
        @(negedge clk);
        check_value("op_ready", 32'd1, 32'(op_ready));
        check_value("in_word", 32'd0, in_word);
        check_value("led", 32'd0, 32'(led));
        check_value("tx", 32'd1, 32'(tx));

        run_out(8'h5a);
        run_in(0);
        check_value("led", 32'h5a, 32'(led));

        // every lane in turn
        for (int lane = 0; lane < 4; lane++) begin
            run_out(8'($urandom));
            run_in(lane);
        end

        // burst past the tx fifo depth
        for (int i = 0; i < 4; i++) begin
            burst[i] = 8'($urandom);
            run_out(burst[i]);
        end
        for (int i = 0; i < 4; i++) begin
            run_in(0);
            check_value("led", 32'(burst[i]), 32'(led));
        end

        run_random(RANDOM_OPS);

        $display("%0d ops run, %0d errors", ops_done, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verif/io_cpu_assertions.sv */
`timescale 1ns/1ps

module io_cpu_assertions (
    input logic clk,
    input logic rstn,
    input logic op_ready,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic tx
);

    logic in_reset;

    // high from the second reset cycle on
    always_ff @(posedge clk) begin
        in_reset <= !rstn;
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn) ack |-> stb)
        else $error("wishbone ack high without stb");

    // issue stays stalled for as long as the sequencer holds the bus
    stall_while_bus: assert property (@(posedge clk) disable iff (!rstn) cyc |-> !op_ready)
        else $error("op_ready high during a bus cycle");

    tx_idle_in_reset: assert property (@(posedge clk) (in_reset && !rstn) |-> tx)
        else $error("tx line low during reset");

endmodule

bind io_cpu io_cpu_assertions u_assertions (
    .clk      (clk),
    .rstn     (rstn),
    .op_ready (op_ready),
    .cyc      (wb.cyc),
    .stb      (wb.stb),
    .ack      (wb.ack),
    .tx       (tx)
);

/* verilog/io_cpu.sv */
`timescale 1ns/1ps

module io_cpu (
    input  logic                clk,
    input  logic                rstn,
    input  logic                op_valid,
    input  cpu_io_pkg::io_op_t  op_code,
    input  cpu_io_pkg::byte_t   op_data,
    output logic                op_ready,
    output cpu_io_pkg::word_t   in_word,
    output cpu_io_pkg::byte_t   led,
    input  logic                rx,
    output logic                tx
);

    io_req_if io_req();
    wb_if     wb();

    // transmitter and receiver handshake
    cpu_io_pkg::byte_t  tx_data;
    logic               tx_start;
    logic               tx_busy;
    cpu_io_pkg::byte_t  rx_data;
    logic               rx_strobe;

    assign led = in_word[7:0];

    //==================================================
    // stage chain
    //==================================================
    io_issue u_issue (
        .clk      (clk),
        .rstn     (rstn),
        .op_valid (op_valid),
        .op_code  (op_code),
        .op_data  (op_data),
        .op_ready (op_ready),
        .in_word  (in_word),
        .req      (io_req.issue)
    );

    io_sequencer u_seq (
        .clk  (clk),
        .rstn (rstn),
        .req  (io_req.seq),
        .bus  (wb.master)
    );

    uart_lite u_uart (
        .clk       (clk),
        .rstn      (rstn),
        .bus       (wb.slave),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    uart_phy u_phy (
        .clk       (clk),
        .rstn      (rstn),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .tx        (tx),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

endmodule

/* verilog/io_sequencer.sv */
`timescale 1ns/1ps
`include "cpu_io_cfg.svh"

module io_sequencer (
    input  logic    clk,
    input  logic    rstn,
    io_req_if.seq   req,
    wb_if.master    bus
);

    cpu_io_pkg::seq_state_t state;

    logic data_phase;
    logic rx_valid;
    logic tx_full;

    assign data_phase = (state == cpu_io_pkg::READ_ST) || (state == cpu_io_pkg::WRITE_ST);
    assign rx_valid   = bus.dat_r[`STAT_RX_VALID_BIT];
    assign tx_full    = bus.dat_r[`STAT_TX_FULL_BIT];

    //==================================================
    // bus signals follow the state
    //==================================================
    // stb stays up across back to back polls, each one ends with ack
    assign bus.cyc   = (state != cpu_io_pkg::RUN_ST);
    assign bus.stb   = (state != cpu_io_pkg::RUN_ST);
    assign bus.we    = (state == cpu_io_pkg::WRITE_ST);
    assign bus.dat_w = cpu_io_pkg::word_t'(req.wdata);

    always_comb begin
        case (state)
            cpu_io_pkg::READ_ST:  bus.adr = cpu_io_pkg::RX_FIFO;
            cpu_io_pkg::WRITE_ST: bus.adr = cpu_io_pkg::TX_FIFO;
            default:              bus.adr = cpu_io_pkg::STAT_REG;
        endcase
    end

    // done on the acked fifo access
    assign req.done  = bus.ack & data_phase;
    assign req.rdata = bus.dat_r[7:0];

    //==================================================
    // poll and access FSM
    //==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= cpu_io_pkg::RUN_ST;
        end else begin
            case (state)
                cpu_io_pkg::RUN_ST: begin
                    if (req.req) begin
                        state <= req.is_out ? cpu_io_pkg::CHECK_TX_ST
                                            : cpu_io_pkg::CHECK_RX_ST;
                    end
                end
                cpu_io_pkg::CHECK_RX_ST: begin
                    // wait for a byte in the rx fifo
                    if (bus.ack && rx_valid) begin
                        state <= cpu_io_pkg::READ_ST;
                    end
                end
                cpu_io_pkg::CHECK_TX_ST: begin
                    // tx fifo full means poll again
                    if (bus.ack && !tx_full) begin
                        state <= cpu_io_pkg::WRITE_ST;
                    end
                end
                cpu_io_pkg::READ_ST,
                cpu_io_pkg::WRITE_ST: begin
                    if (bus.ack) begin
                        state <= cpu_io_pkg::RUN_ST;
                    end
                end
                default: begin
                    state <= cpu_io_pkg::RUN_ST;
                end
            endcase
        end
    end

endmodule

/* verilog/io_issue.sv */
`timescale 1ns/1ps

module io_issue (
    input  logic                clk,
    input  logic                rstn,
    input  logic                op_valid,
    input  cpu_io_pkg::io_op_t  op_code,
    input  cpu_io_pkg::byte_t   op_data,
    output logic                op_ready,
    output cpu_io_pkg::word_t   in_word,
    io_req_if.issue             req
);

    logic       interlock;
    logic       accept;
    logic [1:0] op_lane;
    logic [1:0] lane;

    assign op_ready = ~interlock;
    assign accept   = op_valid & ~interlock;
    // the request lives exactly as long as the stall
    assign req.req  = interlock;

    // byte lane of register 0 for each in variant
    always_comb begin
        case (op_code)
            cpu_io_pkg::OP_IN_LH: op_lane = 2'd1;
            cpu_io_pkg::OP_IN_UL: op_lane = 2'd2;
            cpu_io_pkg::OP_IN_UH: op_lane = 2'd3;
            default:              op_lane = 2'd0;
        endcase
    end

    //==================================================
    // interlock and register 0
    //==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            interlock <= 1'b0;
            in_word   <= '0;
        end else if (accept) begin
            interlock <= 1'b1;
        end else if (interlock && req.done) begin
            interlock <= 1'b0;
            // other lanes keep their value
            if (!req.is_out) begin
                in_word[{lane, 3'b000} +: 8] <= req.rdata;
            end
        end
    end

    // accepted op, held until done
    always_ff @(posedge clk) begin
        if (accept) begin
            req.is_out <= (op_code == cpu_io_pkg::OP_OUT);
            req.wdata  <= op_data;
            lane       <= op_lane;
        end
    end

endmodule

/* uart/uart_lite.sv */
`timescale 1ns/1ps
`include "cpu_io_cfg.svh"

module uart_lite (
    input  logic                clk,
    input  logic                rstn,
    wb_if.slave                 bus,
    output cpu_io_pkg::byte_t   tx_data,
    output logic                tx_start,
    input  logic                tx_busy,
    input  cpu_io_pkg::byte_t   rx_data,
    input  logic                rx_strobe
);

    localparam int RX_AW = $clog2(`RX_FIFO_DEPTH);
    localparam int TX_AW = $clog2(`TX_FIFO_DEPTH);

    cpu_io_pkg::byte_t  rx_mem [`RX_FIFO_DEPTH];
    cpu_io_pkg::byte_t  tx_mem [`TX_FIFO_DEPTH];
    logic [RX_AW-1:0]   rx_wr_ptr, rx_rd_ptr;
    logic [TX_AW-1:0]   tx_wr_ptr, tx_rd_ptr;
    logic [RX_AW:0]     rx_count;
    logic [TX_AW:0]     tx_count;
    logic               rx_empty, rx_full, tx_empty, tx_full;
    logic               access, rx_push, rx_pop, tx_push, tx_pop;
    cpu_io_pkg::word_t  stat;

    assign rx_empty = (rx_count == '0);
    assign tx_empty = (tx_count == '0);
    assign rx_full  = (rx_count == (RX_AW+1)'(`RX_FIFO_DEPTH));
    assign tx_full  = (tx_count == (TX_AW+1)'(`TX_FIFO_DEPTH));

    // new access seen while no ack is out
    assign access  = bus.cyc & bus.stb & ~bus.ack;
    assign rx_push = rx_strobe & ~rx_full;
    assign rx_pop  = access & ~bus.we & (bus.adr == cpu_io_pkg::RX_FIFO) & ~rx_empty;
    assign tx_push = access & bus.we & (bus.adr == cpu_io_pkg::TX_FIFO) & ~tx_full;
    assign tx_pop  = ~tx_empty & ~tx_busy & ~tx_start;

    always_comb begin
        stat = '0;
        stat[`STAT_RX_VALID_BIT] = ~rx_empty;
        stat[`STAT_TX_FULL_BIT]  = tx_full;
    end

    //==================================================
    // fifo pointers and control
    //==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
            rx_count  <= '0;
            tx_wr_ptr <= '0;
            tx_rd_ptr <= '0;
            tx_count  <= '0;
            tx_start  <= 1'b0;
            bus.ack   <= 1'b0;
        end else begin
            rx_wr_ptr <= rx_wr_ptr + RX_AW'(rx_push);
            rx_rd_ptr <= rx_rd_ptr + RX_AW'(rx_pop);
            rx_count  <= rx_count + (RX_AW+1)'(rx_push) - (RX_AW+1)'(rx_pop);
            tx_wr_ptr <= tx_wr_ptr + TX_AW'(tx_push);
            tx_rd_ptr <= tx_rd_ptr + TX_AW'(tx_pop);
            tx_count  <= tx_count + (TX_AW+1)'(tx_push) - (TX_AW+1)'(tx_pop);
            tx_start  <= tx_pop;
            bus.ack   <= access;
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (rx_push) rx_mem[rx_wr_ptr] <= rx_data;
        if (tx_push) tx_mem[tx_wr_ptr] <= bus.dat_w[7:0];
        if (tx_pop) tx_data <= tx_mem[tx_rd_ptr];
        if (access) begin
            case (bus.adr)
                cpu_io_pkg::RX_FIFO:  bus.dat_r <= rx_empty ? '0
                                                 : cpu_io_pkg::word_t'(rx_mem[rx_rd_ptr]);
                cpu_io_pkg::STAT_REG: bus.dat_r <= stat;
                default:              bus.dat_r <= '0;
            endcase
        end
    end

endmodule

/* uart/uart_phy.sv */
`timescale 1ns/1ps
`include "cpu_io_cfg.svh"

module uart_phy (
    input  logic                clk,
    input  logic                rstn,
    input  cpu_io_pkg::byte_t   tx_data,
    input  logic                tx_start,
    output logic                tx_busy,
    output logic                tx,
    input  logic                rx,
    output cpu_io_pkg::byte_t   rx_data,
    output logic                rx_strobe
);

    localparam int BAUD_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BAUD_W-1:0] BAUD_MID  = BAUD_W'(`UART_CLKS_PER_BIT / 2 - 1);

    logic [BAUD_W-1:0]  tx_baud;
    logic [3:0]         tx_bit;
    logic [8:0]         tx_shift;
    logic               tx_tick;

    logic [1:0]         rx_sync;
    logic               rx_s;
    logic               rx_busy;
    logic [BAUD_W-1:0]  rx_baud;
    logic [3:0]         rx_bit;
    logic [7:0]         rx_shift;
    logic               rx_mid;

    assign tx_tick = tx_busy && (tx_baud == BAUD_LAST);
    assign rx_s    = rx_sync[1];
    assign rx_mid  = rx_busy && (rx_baud == BAUD_MID);

    //==================================================
    // transmitter
    //==================================================
    // bit 0 start, 1..8 data lsb first, 9 stop
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_busy <= 1'b0;
            tx      <= 1'b1;
            tx_baud <= '0;
            tx_bit  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                tx      <= 1'b0;
                tx_baud <= '0;
                tx_bit  <= '0;
            end
        end else if (tx_tick) begin
            tx_baud <= '0;
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx     <= tx_shift[0];
                tx_bit <= tx_bit + 4'd1;
            end
        end else begin
            tx_baud <= tx_baud + BAUD_W'(1);
        end
    end

    // ones shift in behind the data to form the stop bit
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            tx_shift <= {1'b1, tx_data};
        end else if (tx_tick) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

    //==================================================
    // receiver
    //==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_sync   <= 2'b11;
            rx_busy   <= 1'b0;
            rx_baud   <= '0;
            rx_bit    <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_sync   <= {rx_sync[0], rx};
            rx_strobe <= 1'b0;
            if (!rx_busy) begin
                if (!rx_s) begin
                    rx_busy <= 1'b1;
                    rx_baud <= '0;
                    rx_bit  <= '0;
                end
            end else begin
                rx_baud <= (rx_baud == BAUD_LAST) ? '0 : rx_baud + BAUD_W'(1);
                if (rx_baud == BAUD_LAST) rx_bit <= rx_bit + 4'd1;
                if (rx_mid) begin
                    // glitch on the start bit
                    if (rx_bit == 4'd0 && rx_s) begin
                        rx_busy <= 1'b0;
                    end else if (rx_bit == 4'd9) begin
                        rx_busy   <= 1'b0;
                        rx_strobe <= rx_s;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_mid && rx_bit >= 4'd1 && rx_bit <= 4'd8) rx_shift <= {rx_s, rx_shift[7:1]};
        if (rx_mid && rx_bit == 4'd9 && rx_s) rx_data <= rx_shift;
    end

endmodule

/* common/cpu_io_if.sv */
`timescale 1ns/1ps

// request from issue to the bus sequencer
interface io_req_if;
    logic               req;
    logic               is_out;
    cpu_io_pkg::byte_t  wdata;
    logic               done;
    cpu_io_pkg::byte_t  rdata;

    modport issue (output req, output is_out, output wdata,
                   input done, input rdata);
    modport seq   (input req, input is_out, input wdata,
                   output done, output rdata);
endinterface

// wishbone classic, single access
interface wb_if;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    cpu_io_pkg::bus_addr_t  adr;
    cpu_io_pkg::word_t      dat_w;
    cpu_io_pkg::word_t      dat_r;
    logic                   ack;

    modport master (output cyc, output stb, output we, output adr,
                    output dat_w, input dat_r, input ack);
    modport slave  (input cyc, input stb, input we, input adr,
                    input dat_w, output dat_r, output ack);
endinterface

/* common/cpu_io_pkg.sv */
package cpu_io_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  bus_addr_t;

    // in variants map to byte lanes 0..3 of register 0
    typedef enum logic [2:0] {
        OP_OUT,
        OP_IN_LL,
        OP_IN_LH,
        OP_IN_UL,
        OP_IN_UH
    } io_op_t;

    // wishbone register map of the uart block
    typedef enum logic [3:0] {
        RX_FIFO  = 4'h0,
        TX_FIFO  = 4'h4,
        STAT_REG = 4'h8
    } uart_reg_t;

    typedef enum logic [2:0] {
        RUN_ST,
        CHECK_RX_ST,
        READ_ST,
        CHECK_TX_ST,
        WRITE_ST
    } seq_state_t;

endpackage

/* common/cpu_io_cfg.svh */
`ifndef CPU_IO_CFG_SVH
`define CPU_IO_CFG_SVH

//==================================================
// serial line
//==================================================

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 8

//==================================================
// uart register block
//==================================================

// depths must stay powers of two
`define RX_FIFO_DEPTH 4
`define TX_FIFO_DEPTH 2

// status register bit positions
`define STAT_RX_VALID_BIT 0
`define STAT_TX_FULL_BIT 3

`endif
